// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= video_resize_half_tb
FILELIST  ?= video_resize_half.f
LOG       ?= sim.log
PASS_MSG  := Everything OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation reported failure"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// ==== logic/line_decimator.sv ====
// ----------------------------------------------------------------------
// line decimator
// register slice dropping odd lines when vertical halving is on
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module line_decimator (
    input  logic                            aclk,
    input  logic                            reset,
    input  logic                            s_valid,
    output logic                            s_ready,
    input  video_half_pkg::video_beat_t     in_beat,
    input  video_half_pkg::position_t       position,
    input  video_half_pkg::resize_param_t   active_param,
    output logic                            m_valid,
    input  logic                            m_ready,
    output video_half_pkg::video_beat_t     out_beat,
    output logic                            out_x_odd
);

    import video_half_pkg::*;

    video_beat_t beat_q;
    logic        x_odd_q;
    logic        valid_q;
    logic        accept;
    logic        keep;

    assign s_ready = !valid_q || m_ready;
    assign accept  = s_valid && s_ready;
    // enable sampled on acceptance only
    assign keep    = !active_param.v_enable || !position.y_odd;

    always_ff @(posedge aclk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= keep;
        end else if (m_ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (accept && keep) begin
            beat_q  <= in_beat;
            x_odd_q <= position.x_odd;
        end
    end

    assign m_valid   = valid_q;
    assign out_beat  = beat_q;
    assign out_x_odd = x_odd_q;

endmodule

// ==== logic/pair_averager.sv ====
// ----------------------------------------------------------------------
// pair averager
// averages even/odd pixel pairs when horizontal halving is on
// ----------------------------------------------------------------------

`timescale 1ns/1ns

`include "video_half_config.svh"

module pair_averager (
    input  logic                            aclk,
    input  logic                            reset,
    input  logic                            s_valid,
    output logic                            s_ready,
    input  video_half_pkg::video_beat_t     in_beat,
    input  logic                            in_x_odd,
    input  video_half_pkg::resize_param_t   active_param,
    output logic                            m_valid,
    input  logic                            m_ready,
    output video_half_pkg::video_beat_t     out_beat
);

    import video_half_pkg::*;

    // held even pixel and the mode it was taken in
    pixel_t      hold_pixel;
    logic        hold_tuser;
    logic        hold_h;

    video_beat_t avg_beat;
    video_beat_t beat_q;
    logic        valid_q;
    logic        accept;
    logic        hold_in;
    logic        pair_out;

    assign s_ready  = !valid_q || m_ready;
    assign accept   = s_valid && s_ready;
    assign hold_in  = !in_x_odd && active_param.h_enable;
    assign pair_out = in_x_odd && hold_h;

    // ------------------------------------------------------------------
    // per-component floor average
    // ------------------------------------------------------------------
    always_comb begin
        logic [`VH_DATA_WIDTH:0] sum;
        avg_beat.tuser = hold_tuser;
        avg_beat.tlast = in_beat.tlast;
        avg_beat.pixel = '0;
        for (int c = 0; c < `VH_COMPONENT_NUM; c++) begin
            sum = {1'b0, hold_pixel[c]} + {1'b0, in_beat.pixel[c]};
            avg_beat.pixel[c] = sum[`VH_DATA_WIDTH:1];
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            valid_q <= 1'b0;
            hold_h  <= 1'b0;
        end else begin
            if (accept && !hold_in) begin
                valid_q <= 1'b1;
            end else if (m_ready) begin
                valid_q <= 1'b0;
            end
            if (accept && !in_x_odd) begin
                hold_h <= active_param.h_enable;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (accept && !in_x_odd) begin
            hold_pixel <= in_beat.pixel;
            hold_tuser <= in_beat.tuser;
        end
        if (accept && !hold_in) begin
            beat_q <= pair_out ? avg_beat : in_beat;
        end
    end

    assign m_valid  = valid_q;
    assign out_beat = beat_q;

endmodule

// ==== logic/pixel_position_counter.sv ====
// ----------------------------------------------------------------------
// pixel position counter
// column and line parity of the beat on the input
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module pixel_position_counter (
    input  logic                            aclk,
    input  logic                            reset,
    input  logic                            s_valid,
    input  logic                            s_ready,
    input  video_half_pkg::video_beat_t     in_beat,
    output video_half_pkg::position_t       position
);

    import video_half_pkg::*;

    position_t pos_q;

    // frame start is always column 0 of line 0
    assign position = in_beat.tuser ? '0 : pos_q;

    always_ff @(posedge aclk) begin
        if (reset) begin
            pos_q <= '0;
        end else if (s_valid && s_ready) begin
            if (in_beat.tlast) begin
                pos_q.x_odd <= 1'b0;
                pos_q.y_odd <= ~position.y_odd;
            end else begin
                pos_q.x_odd <= ~position.x_odd;
                pos_q.y_odd <= position.y_odd;
            end
        end
    end

endmodule

// ==== logic/shadow_update_fsm.sv ====
// ----------------------------------------------------------------------
// shadow update controller
// loads the shadow enables at the next accepted frame start
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module shadow_update_fsm (
    input  logic aclk,
    input  logic reset,
    input  logic update_req,
    input  logic s_valid,
    input  logic s_ready,
    input  logic frame_start,
    output logic shadow_load,
    output logic update_ack
);

    import video_half_pkg::*;

    update_state_e state;
    logic          frame_accept;

    assign frame_accept = s_valid && s_ready && frame_start;

    always_ff @(posedge aclk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (update_req) begin
                        state <= st_pending;
                    end
                end
                st_pending: begin
                    if (frame_accept) begin
                        state <= st_ack;
                    end
                end
                st_ack: begin
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // load in the same cycle as the frame-start handshake
    assign shadow_load = (state == st_pending) && frame_accept;
    assign update_ack  = (state == st_ack);

endmodule

// ==== logic/video_half_config.svh ====
// ----------------------------------------------------------------------
// video half-scaler configuration
// pixel format, update index and register bus sizes
// ----------------------------------------------------------------------

`ifndef VIDEO_HALF_CONFIG_SVH
`define VIDEO_HALF_CONFIG_SVH

// pixel format
`define VH_COMPONENT_NUM    3
`define VH_DATA_WIDTH       8

// update index wraps on overflow
`define VH_INDEX_WIDTH      2

// register bus
`define VH_REG_ADDR_WIDTH   2
`define VH_REG_DATA_WIDTH   32

`endif

// ==== logic/video_half_pkg.sv ====
// ----------------------------------------------------------------------
// video half-scaler types
// stream beats, positions, parameters, states and register map
// ----------------------------------------------------------------------

`include "video_half_config.svh"

package video_half_pkg;

    typedef logic [`VH_COMPONENT_NUM-1:0][`VH_DATA_WIDTH-1:0] pixel_t;

    typedef struct packed {
        logic   tuser;
        logic   tlast;
        pixel_t pixel;
    } video_beat_t;

    typedef struct packed {
        logic x_odd;
        logic y_odd;
    } position_t;

    typedef struct packed {
        logic v_enable;
        logic h_enable;
    } resize_param_t;

    typedef enum logic [1:0] {
        st_idle,
        st_pending,
        st_ack
    } update_state_e;

    typedef enum logic [`VH_REG_ADDR_WIDTH-1:0] {
        reg_ctl_update     = 2'd0,
        reg_ctl_index      = 2'd1,
        reg_param_v_enable = 2'd2,
        reg_param_h_enable = 2'd3
    } reg_addr_e;

endpackage

// ==== logic/video_half_regs.sv ====
// ----------------------------------------------------------------------
// video half-scaler register block
// control registers, read mux and shadow copy of the enables
// ----------------------------------------------------------------------

`timescale 1ns/1ns

`include "video_half_config.svh"

module video_half_regs (
    input  logic                                aclk,
    input  logic                                reset,
    input  logic                                reg_wr_en,
    input  video_half_pkg::reg_addr_e           reg_wr_addr,
    input  logic [`VH_REG_DATA_WIDTH-1:0]       reg_wr_data,
    input  video_half_pkg::reg_addr_e           reg_rd_addr,
    output logic [`VH_REG_DATA_WIDTH-1:0]       reg_rd_data,
    output logic                                update_req,
    input  logic                                shadow_load,
    input  logic                                update_ack,
    output video_half_pkg::resize_param_t       active_param
);

    import video_half_pkg::*;

    logic                           ctl_update;
    logic [`VH_INDEX_WIDTH-1:0]     ctl_index;
    resize_param_t                  live_param;
    resize_param_t                  shadow_param;

    // ------------------------------------------------------------------
    // register writes
    // ------------------------------------------------------------------
    always_ff @(posedge aclk) begin
        if (reset) begin
            ctl_update          <= 1'b0;
            ctl_index           <= '0;
            live_param.v_enable <= 1'b1;
            live_param.h_enable <= 1'b1;
        end else begin
            if (reg_wr_en) begin
                case (reg_wr_addr)
                    reg_ctl_update:     ctl_update          <= reg_wr_data[0];
                    reg_param_v_enable: live_param.v_enable <= reg_wr_data[0];
                    reg_param_h_enable: live_param.h_enable <= reg_wr_data[0];
                    default: ;
                endcase
            end
            // request clears itself once the shadow load is done
            if (update_ack) begin
                ctl_update <= 1'b0;
                ctl_index  <= ctl_index + 1'b1;
            end
        end
    end

    always_comb begin
        reg_rd_data = '0;
        case (reg_rd_addr)
            reg_ctl_update:     reg_rd_data[0] = ctl_update;
            reg_ctl_index:      reg_rd_data[`VH_INDEX_WIDTH-1:0] = ctl_index;
            reg_param_v_enable: reg_rd_data[0] = live_param.v_enable;
            reg_param_h_enable: reg_rd_data[0] = live_param.h_enable;
            default:            reg_rd_data = '0;
        endcase
    end

    // ------------------------------------------------------------------
    // shadow copy
    // ------------------------------------------------------------------
    always_ff @(posedge aclk) begin
        if (reset) begin
            shadow_param.v_enable <= 1'b1;
            shadow_param.h_enable <= 1'b1;
        end else if (shadow_load) begin
            shadow_param <= live_param;
        end
    end

    // new settings already govern the frame-start beat itself
    assign active_param = shadow_load ? live_param : shadow_param;
    assign update_req   = ctl_update;

endmodule

// ==== logic/video_resize_half.sv ====
// ----------------------------------------------------------------------
// video half-scaler top
// register block, update control and two-stage halving datapath
// ----------------------------------------------------------------------

`timescale 1ns/1ns

`include "video_half_config.svh"

module video_resize_half (
    input  logic                            aclk,
    input  logic                            reset,
    input  logic                            reg_wr_en,
    input  video_half_pkg::reg_addr_e       reg_wr_addr,
    input  logic [`VH_REG_DATA_WIDTH-1:0]   reg_wr_data,
    input  video_half_pkg::reg_addr_e       reg_rd_addr,
    output logic [`VH_REG_DATA_WIDTH-1:0]   reg_rd_data,
    input  logic                            s_valid,
    output logic                            s_ready,
    input  video_half_pkg::video_beat_t     s_beat,
    output logic                            m_valid,
    input  logic                            m_ready,
    output video_half_pkg::video_beat_t     m_beat
);

    import video_half_pkg::*;

    logic          update_req;
    logic          shadow_load;
    logic          update_ack;
    resize_param_t active_param;
    position_t     position;

    // between decimator and averager
    logic          mid_valid;
    logic          mid_ready;
    video_beat_t   mid_beat;
    logic          mid_x_odd;

    video_half_regs video_half_regs_inst (
        .aclk         (aclk),
        .reset        (reset),
        .reg_wr_en    (reg_wr_en),
        .reg_wr_addr  (reg_wr_addr),
        .reg_wr_data  (reg_wr_data),
        .reg_rd_addr  (reg_rd_addr),
        .reg_rd_data  (reg_rd_data),
        .update_req   (update_req),
        .shadow_load  (shadow_load),
        .update_ack   (update_ack),
        .active_param (active_param)
    );

    shadow_update_fsm shadow_update_fsm_inst (
        .aclk        (aclk),
        .reset       (reset),
        .update_req  (update_req),
        .s_valid     (s_valid),
        .s_ready     (s_ready),
        .frame_start (s_beat.tuser),
        .shadow_load (shadow_load),
        .update_ack  (update_ack)
    );

    pixel_position_counter pixel_position_counter_inst (
        .aclk     (aclk),
        .reset    (reset),
        .s_valid  (s_valid),
        .s_ready  (s_ready),
        .in_beat  (s_beat),
        .position (position)
    );

    line_decimator line_decimator_inst (
        .aclk         (aclk),
        .reset        (reset),
        .s_valid      (s_valid),
        .s_ready      (s_ready),
        .in_beat      (s_beat),
        .position     (position),
        .active_param (active_param),
        .m_valid      (mid_valid),
        .m_ready      (mid_ready),
        .out_beat     (mid_beat),
        .out_x_odd    (mid_x_odd)
    );

    pair_averager pair_averager_inst (
        .aclk         (aclk),
        .reset        (reset),
        .s_valid      (mid_valid),
        .s_ready      (mid_ready),
        .in_beat      (mid_beat),
        .in_x_odd     (mid_x_odd),
        .active_param (active_param),
        .m_valid      (m_valid),
        .m_ready      (m_ready),
        .out_beat     (m_beat)
    );

endmodule

// ==== test/video_half_stimulus.txt ====
# W addr data: register write    R addr expected: register read and compare
# F width height: one frame of pseudo-random pixels
R 0 0
R 1 0
R 2 1
R 3 1
F 16 8
W 2 0
R 2 0
F 16 8
W 0 1
R 0 1
F 16 8
R 0 0
R 1 1
W 3 0
W 2 1
W 0 1
F 16 6
R 1 2
W 2 0
W 0 1
F 8 4
R 1 3
W 2 1
W 3 1
W 0 1
F 12 6
R 1 0
R 0 0

// ==== test/video_resize_half_sva.sv ====
// ----------------------------------------------------------------------
// video half-scaler assertions
// output hold, update handshake and reset state
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module video_resize_half_sva (
    input logic                         aclk,
    input logic                         reset,
    input logic                         m_valid,
    input logic                         m_ready,
    input video_half_pkg::video_beat_t  m_beat,
    input logic                         shadow_load,
    input logic                         update_ack
);

    // a stalled beat stays put
    hold_stable: assert property (@(posedge aclk) disable iff (reset)
        m_valid && !m_ready |=> m_valid && $stable(m_beat))
        else $error("output beat changed while stalled");

    ack_after_load: assert property (@(posedge aclk) disable iff (reset)
        update_ack |-> $past(shadow_load))
        else $error("update acknowledged without a shadow load");

    reset_output: assert property (@(posedge aclk)
        reset |=> !m_valid)
        else $error("output valid right after reset");

endmodule

bind video_resize_half video_resize_half_sva video_resize_half_sva_inst (
    .aclk        (aclk),
    .reset       (reset),
    .m_valid     (m_valid),
    .m_ready     (m_ready),
    .m_beat      (m_beat),
    .shadow_load (shadow_load),
    .update_ack  (update_ack)
);

// ==== test/video_resize_half_tb.sv ====
// ----------------------------------------------------------------------
// video half-scaler testbench
// file-driven register and frame tests against a reference model
// ----------------------------------------------------------------------

`timescale 1ns/1ns

`include "video_half_config.svh"

module video_resize_half_tb;

    import video_half_pkg::*;

    logic                           aclk;
    logic                           reset;
    logic                           reg_wr_en;
    reg_addr_e                      reg_wr_addr;
    logic [`VH_REG_DATA_WIDTH-1:0]  reg_wr_data;
    reg_addr_e                      reg_rd_addr;
    logic [`VH_REG_DATA_WIDTH-1:0]  reg_rd_data;
    logic                           s_valid;
    logic                           s_ready;
    video_beat_t                    s_beat;
    logic                           m_valid;
    logic                           m_ready;
    video_beat_t                    m_beat;

    video_beat_t    frame_beats[$];
    video_beat_t    expected_q[$];
    video_beat_t    exp_beat;
    byte            cmd_kind[$];
    int             cmd_a[$];
    int             cmd_b[$];
    logic [31:0]    pixel_state = 32'd40;
    logic [31:0]    stall_state = 32'd40;
    int             cycle_count = 0;
    int             cycle_limit = 1000;
    int             out_count = 0;
    int             beat_errors = 0;
    int             reg_errors = 0;
    int             other_errors = 0;
    // model of the register block
    resize_param_t  live_param;
    resize_param_t  shadow_param;
    logic           update_pending;

    video_resize_half video_resize_half_inst (.*);

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // ------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------
    task automatic check_beat(input string name, input video_beat_t expected,
                              input video_beat_t actual);
        if (actual !== expected) begin
            beat_errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_reg(input string name, input logic [`VH_REG_DATA_WIDTH-1:0] expected,
                             input logic [`VH_REG_DATA_WIDTH-1:0] actual);
        if (actual !== expected) begin
            reg_errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // ------------------------------------------------------------------
    // stimulus and reference model
    // ------------------------------------------------------------------
    task automatic write_reg(input int addr, input int data);
        reg_wr_en   = 1'b1;
        reg_wr_addr = reg_addr_e'(addr[1:0]);
        reg_wr_data = data;
        @(posedge aclk);
        #1;
        reg_wr_en = 1'b0;
        case (addr)
            0: update_pending = data[0];
            2: live_param.v_enable = data[0];
            3: live_param.h_enable = data[0];
            default: ;
        endcase
        // controller reaches pending one cycle after the request
        repeat (2) @(posedge aclk);
        #1;
    endtask

    task automatic read_reg(input int addr, input int expected);
        reg_rd_addr = reg_addr_e'(addr[1:0]);
        @(posedge aclk);
        check_reg($sformatf("read of register %0d", addr), expected, reg_rd_data);
        #1;
    endtask

    // pixels of one frame plus its expected output, under the frame's enables
    task automatic build_frame(input int width, input int height);
        video_beat_t beat;
        video_beat_t even;
        video_beat_t avg;
        frame_beats.delete();
        if (update_pending) begin
            shadow_param   = live_param;
            update_pending = 1'b0;
        end
        for (int y = 0; y < height; y++) begin
            for (int x = 0; x < width; x++) begin
                pixel_state = xorshift32(pixel_state);
                beat.tuser  = (x == 0 && y == 0);
                beat.tlast  = (x == width - 1);
                beat.pixel  = pixel_state[23:0];
                frame_beats.push_back(beat);
                if (shadow_param.v_enable && y % 2 == 1) continue;
                if (!shadow_param.h_enable) begin
                    expected_q.push_back(beat);
                end else if (x % 2 == 0) begin
                    even = beat;
                end else begin
                    avg.tuser = even.tuser;
                    avg.tlast = beat.tlast;
                    for (int c = 0; c < `VH_COMPONENT_NUM; c++) begin
                        avg.pixel[c] = `VH_DATA_WIDTH'((int'(even.pixel[c])
                                       + int'(beat.pixel[c])) / 2);
                    end
                    expected_q.push_back(avg);
                end
            end
        end
    endtask

    task automatic send_frame();
        foreach (frame_beats[i]) begin
            s_valid = 1'b1;
            s_beat  = frame_beats[i];
            @(posedge aclk);
            while (!s_ready) @(posedge aclk);
            #1;
        end
        s_valid = 1'b0;
    endtask

    task automatic drain_output();
        while (expected_q.size() != 0) @(negedge aclk);
        repeat (2) @(posedge aclk);
        #1;
    endtask

    // ------------------------------------------------------------------
    // output side
    // ------------------------------------------------------------------
    initial begin
        m_ready = 1'b0;
        forever begin
            @(posedge aclk);
            #1;
            stall_state = xorshift32(stall_state);
            m_ready = (stall_state[1:0] != 2'b00);
        end
    end

    always @(posedge aclk) begin
        if (!reset && m_valid && m_ready) begin
            if (expected_q.size() == 0) begin
                other_errors++;
                $display("output beat %0d arrived when no beat was expected", out_count);
            end else begin
                exp_beat = expected_q.pop_front();
                check_beat($sformatf("output beat %0d", out_count), exp_beat, m_beat);
            end
            out_count++;
        end
    end

    always @(posedge aclk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Something failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------
    initial begin
        int    fd;
        int    n;
        int    a;
        int    b;
        int    total_beats;
        string line;
        reset          = 1'b1;
        reg_wr_en      = 1'b0;
        reg_wr_addr    = reg_ctl_update;
        reg_wr_data    = '0;
        reg_rd_addr    = reg_ctl_update;
        s_valid        = 1'b0;
        s_beat         = '0;
        live_param     = '1;
        shadow_param   = '1;
        update_pending = 1'b0;
        total_beats    = 0;
        fd = $fopen("test/video_half_stimulus.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("could not open the stimulus file");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 2 && (line.getc(0) == "W" || line.getc(0) == "R"
                              || line.getc(0) == "F")) begin
                    n = $sscanf(line.substr(1, line.len() - 1), "%d %d", a, b);
                    if (n == 2) begin
                        cmd_kind.push_back(line.getc(0));
                        cmd_a.push_back(a);
                        cmd_b.push_back(b);
                        if (line.getc(0) == "F") total_beats += a * b;
                    end else begin
                        other_errors++;
                        $display("stimulus line could not be parsed: %s", line);
                    end
                end
            end
            $fclose(fd);
        end
        cycle_limit = total_beats * 4 + 1000;

        repeat (5) @(posedge aclk);
        #1;
        reset = 1'b0;

        foreach (cmd_kind[i]) begin
            case (cmd_kind[i])
                "W": write_reg(cmd_a[i], cmd_b[i]);
                "R": read_reg(cmd_a[i], cmd_b[i]);
                default: begin
                    build_frame(cmd_a[i], cmd_b[i]);
                    send_frame();
                    drain_output();
                end
            endcase
        end

        $display("%0d beats checked, %0d beat errors, %0d register errors, %0d other errors",
                 out_count, beat_errors, reg_errors, other_errors);
        if (beat_errors + reg_errors + other_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== video_resize_half.f ====
+incdir+logic
logic/video_half_pkg.sv
logic/video_half_regs.sv
logic/shadow_update_fsm.sv
logic/pixel_position_counter.sv
logic/line_decimator.sv
logic/pair_averager.sv
logic/video_resize_half.sv
test/video_resize_half_sva.sv
test/video_resize_half_tb.sv
